//--- logic/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// Bus widths
`define ADDR_W 32
`define DATA_W 32

// SoC side IDs are wide, external side IDs index the remap table
`define SRC_ID_W 6
`define DST_ID_W 2

// Outstanding limits
`define MAX_TXN_PER_ID 4
`define NUM_PENDING 8

// Async FIFO depth is 2**LOG_DEPTH
`define LOG_DEPTH 2
`define SYNC_STAGES 2

`endif

//--- logic/axi_bridge_pkg.sv
`include "bridge_config.svh"

package axi_bridge_pkg;

  // SoC side request and response
  typedef struct packed {
    logic [`ADDR_W-1:0]   addr;
    logic [`DATA_W-1:0]   wdata;
    logic                 write;
    logic [`SRC_ID_W-1:0] id;
  } src_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0]   rdata;
    logic [`SRC_ID_W-1:0] id;
  } src_rsp_t;

  // External side, ID narrowed to a table index
  typedef struct packed {
    logic [`ADDR_W-1:0]   addr;
    logic [`DATA_W-1:0]   wdata;
    logic                 write;
    logic [`DST_ID_W-1:0] id;
  } dst_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0]   rdata;
    logic [`DST_ID_W-1:0] id;
  } dst_rsp_t;

  // Gray pointer with wrap bit
  typedef logic [`LOG_DEPTH:0] ptr_t;

  typedef enum logic [1:0] {
    ISO_OPEN     = 2'd0,
    ISO_DRAIN    = 2'd1,
    ISO_ISOLATED = 2'd2
  } iso_state_e;

endpackage

//--- logic/axi_id_remap.sv
`timescale 1ns/100ps
`include "bridge_config.svh"

module axi_id_remap
  import axi_bridge_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  src_req_t slv_req_i,
  input  logic     slv_req_valid_i,
  output logic     slv_req_ready_o,
  output src_rsp_t slv_rsp_o,
  output logic     slv_rsp_valid_o,
  input  logic     slv_rsp_ready_i,
  output dst_req_t mst_req_o,
  output logic     mst_req_valid_o,
  input  logic     mst_req_ready_i,
  input  dst_rsp_t mst_rsp_i,
  input  logic     mst_rsp_valid_i,
  output logic     mst_rsp_ready_o
);

  localparam int unsigned NUM_ENTRIES = 1 << `DST_ID_W;
  localparam int unsigned ID_W        = `DST_ID_W;
  localparam int unsigned CNT_W       = $clog2(`MAX_TXN_PER_ID + 1);

  logic [`SRC_ID_W-1:0] tbl_id_q [NUM_ENTRIES];
  logic [CNT_W-1:0]     cnt_q    [NUM_ENTRIES];

  logic            hit, free, held_q, can_go;
  logic [ID_W-1:0] hit_idx, free_idx, sel_idx, held_idx_q;
  logic            req_fire, rsp_fire;

  // Live entry with the same source ID, else lowest free entry
  always_comb begin
    hit      = 1'b0;
    hit_idx  = '0;
    free     = 1'b0;
    free_idx = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (cnt_q[i] != '0 && tbl_id_q[i] == slv_req_i.id) begin
        hit     = 1'b1;
        hit_idx = ID_W'(i);
      end
      if (cnt_q[i] == '0) begin
        free     = 1'b1;
        free_idx = ID_W'(i);
      end
    end
  end

  // A stalled request keeps its index so the payload stays stable
  assign sel_idx = held_q ? held_idx_q : (hit ? hit_idx : free_idx);
  assign can_go  = (held_q || hit || free) && cnt_q[sel_idx] != CNT_W'(`MAX_TXN_PER_ID);

  always_comb begin
    mst_req_o.addr  = slv_req_i.addr;
    mst_req_o.wdata = slv_req_i.wdata;
    mst_req_o.write = slv_req_i.write;
    mst_req_o.id    = sel_idx;
  end

  assign mst_req_valid_o = slv_req_valid_i && can_go;
  assign slv_req_ready_o = mst_req_ready_i && can_go;
  assign req_fire        = mst_req_valid_o && mst_req_ready_i;

  // Response path restores the wide ID
  assign slv_rsp_o.rdata = mst_rsp_i.rdata;
  assign slv_rsp_o.id    = tbl_id_q[mst_rsp_i.id];
  assign slv_rsp_valid_o = mst_rsp_valid_i;
  assign mst_rsp_ready_o = slv_rsp_ready_i;
  assign rsp_fire        = mst_rsp_valid_i && slv_rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_q <= 1'b0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      held_q <= mst_req_valid_o && !mst_req_ready_i;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        cnt_q[i] <= cnt_q[i] + CNT_W'(req_fire && sel_idx == ID_W'(i))
                             - CNT_W'(rsp_fire && mst_rsp_i.id == ID_W'(i));
      end
    end
  end

  always_ff @(posedge clk_i) begin
    held_idx_q <= sel_idx;
    if (req_fire) begin
      tbl_id_q[sel_idx] <= slv_req_i.id;
    end
  end

  // Remote side only answers IDs it was given
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_rsp_valid_i |-> cnt_q[mst_rsp_i.id] != '0)
    else $error("axi_id_remap: response for idle entry %0d", mst_rsp_i.id);

endmodule

//--- logic/axi_isolate.sv
`timescale 1ns/100ps
`include "bridge_config.svh"

module axi_isolate
  import axi_bridge_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     isolate_i,
  output logic     isolated_o,
  input  dst_req_t slv_req_i,
  input  logic     slv_req_valid_i,
  output logic     slv_req_ready_o,
  output dst_rsp_t slv_rsp_o,
  output logic     slv_rsp_valid_o,
  input  logic     slv_rsp_ready_i,
  output dst_req_t mst_req_o,
  output logic     mst_req_valid_o,
  input  logic     mst_req_ready_i,
  input  dst_rsp_t mst_rsp_i,
  input  logic     mst_rsp_valid_i,
  output logic     mst_rsp_ready_o
);

  localparam int unsigned PEND_W = $clog2(`NUM_PENDING + 1);

  iso_state_e        state_q, state_d;
  logic [PEND_W-1:0] pending_q;
  logic              held_q, pass, stall, req_fire, rsp_fire;

  // A request already presented downstream is let through before blocking
  assign pass = state_q == ISO_OPEN && pending_q != PEND_W'(`NUM_PENDING)
                && (!isolate_i || held_q);

  assign mst_req_o       = slv_req_i;
  assign mst_req_valid_o = slv_req_valid_i && pass;
  assign slv_req_ready_o = mst_req_ready_i && pass;
  assign slv_rsp_o       = mst_rsp_i;
  assign slv_rsp_valid_o = mst_rsp_valid_i;
  assign mst_rsp_ready_o = slv_rsp_ready_i;

  assign stall      = mst_req_valid_o && !mst_req_ready_i;
  assign req_fire   = mst_req_valid_o && mst_req_ready_i;
  assign rsp_fire   = mst_rsp_valid_i && slv_rsp_ready_i;
  assign isolated_o = state_q == ISO_ISOLATED;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ISO_OPEN: begin
        if (isolate_i && !stall) begin
          state_d = ISO_DRAIN;
        end
      end
      ISO_DRAIN: begin
        if (!isolate_i) begin
          state_d = ISO_OPEN;
        end else if (pending_q == '0) begin
          state_d = ISO_ISOLATED;
        end
      end
      ISO_ISOLATED: begin
        if (!isolate_i) begin
          state_d = ISO_OPEN;
        end
      end
      default: state_d = ISO_OPEN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= ISO_OPEN;
      pending_q <= '0;
      held_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      pending_q <= pending_q + PEND_W'(req_fire) - PEND_W'(rsp_fire);
      held_q    <= stall;
    end
  end

  // Every response matches an earlier request
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_fire |-> pending_q != '0)
    else $error("axi_isolate: pending count underflow");

endmodule

//--- logic/axi_cdc_src.sv
`timescale 1ns/100ps
`include "bridge_config.svh"

module axi_cdc_src
  import axi_bridge_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  dst_req_t                         req_i,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  output dst_rsp_t                         rsp_o,
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i,
  output dst_req_t [(1 << `LOG_DEPTH)-1:0] async_req_data_o,
  output ptr_t                             async_req_wptr_o,
  input  ptr_t                             async_req_rptr_i,
  input  dst_rsp_t [(1 << `LOG_DEPTH)-1:0] async_rsp_data_i,
  input  ptr_t                             async_rsp_wptr_i,
  output ptr_t                             async_rsp_rptr_o
);

  // Full when the two MSBs of the Gray pointers differ and the rest match
  localparam ptr_t FULL_MASK = ptr_t'(3) << (`LOG_DEPTH - 1);

  // Index 0 is the remote read pointer, index 1 the remote write pointer
  ptr_t [1:0] sync_q [`SYNC_STAGES];
  ptr_t       req_rptr_s, rsp_wptr_s;
  ptr_t       wptr_bin_q, rptr_bin_q;
  logic       rdy_q, full, req_fire, rsp_fire;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= {async_rsp_wptr_i, async_req_rptr_i};
      for (int i = 1; i < `SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign req_rptr_s = sync_q[`SYNC_STAGES-1][0];
  assign rsp_wptr_s = sync_q[`SYNC_STAGES-1][1];

  // Request writer
  assign full        = async_req_wptr_o == (req_rptr_s ^ FULL_MASK);
  assign req_ready_o = rdy_q && !full;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdy_q            <= 1'b0;
      wptr_bin_q       <= '0;
      async_req_wptr_o <= '0;
    end else begin
      // Hold off requests until the first edge out of reset
      rdy_q <= 1'b1;
      if (req_fire) begin
        wptr_bin_q       <= wptr_bin_q + ptr_t'(1);
        async_req_wptr_o <= bin2gray(wptr_bin_q + ptr_t'(1));
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      async_req_data_o[wptr_bin_q[`LOG_DEPTH-1:0]] <= req_i;
    end
  end

  // Response reader, head word straight from the remote array
  assign rsp_valid_o = async_rsp_rptr_o != rsp_wptr_s;
  assign rsp_o       = async_rsp_data_i[rptr_bin_q[`LOG_DEPTH-1:0]];
  assign rsp_fire    = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rptr_bin_q       <= '0;
      async_rsp_rptr_o <= '0;
    end else if (rsp_fire) begin
      rptr_bin_q       <= rptr_bin_q + ptr_t'(1);
      async_rsp_rptr_o <= bin2gray(rptr_bin_q + ptr_t'(1));
    end
  end

  // Live remote read pointer must still leave a free slot on every write
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_fire |-> async_req_wptr_o != (async_req_rptr_i ^ FULL_MASK))
    else $error("axi_cdc_src: write while full");

endmodule

//--- logic/ext_slv_port.sv
`timescale 1ns/100ps
`include "bridge_config.svh"

module ext_slv_port
  import axi_bridge_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             isolate_i,
  output logic                             isolated_o,
  input  src_req_t                         req_i,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  output src_rsp_t                         rsp_o,
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i,
  output dst_req_t [(1 << `LOG_DEPTH)-1:0] async_req_data_o,
  output ptr_t                             async_req_wptr_o,
  input  ptr_t                             async_req_rptr_i,
  input  dst_rsp_t [(1 << `LOG_DEPTH)-1:0] async_rsp_data_i,
  input  ptr_t                             async_rsp_wptr_i,
  output ptr_t                             async_rsp_rptr_o
);

  // Remap to isolate, isolate to CDC
  dst_req_t remap_req, iso_req;
  dst_rsp_t remap_rsp, iso_rsp;
  logic     remap_req_valid, remap_req_ready, remap_rsp_valid, remap_rsp_ready;
  logic     iso_req_valid, iso_req_ready, iso_rsp_valid, iso_rsp_ready;

  axi_id_remap i_axi_id_remap (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .slv_req_i       (req_i),
    .slv_req_valid_i (req_valid_i),
    .slv_req_ready_o (req_ready_o),
    .slv_rsp_o       (rsp_o),
    .slv_rsp_valid_o (rsp_valid_o),
    .slv_rsp_ready_i (rsp_ready_i),
    .mst_req_o       (remap_req),
    .mst_req_valid_o (remap_req_valid),
    .mst_req_ready_i (remap_req_ready),
    .mst_rsp_i       (remap_rsp),
    .mst_rsp_valid_i (remap_rsp_valid),
    .mst_rsp_ready_o (remap_rsp_ready)
  );

  axi_isolate i_axi_isolate (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .isolate_i       (isolate_i),
    .isolated_o      (isolated_o),
    .slv_req_i       (remap_req),
    .slv_req_valid_i (remap_req_valid),
    .slv_req_ready_o (remap_req_ready),
    .slv_rsp_o       (remap_rsp),
    .slv_rsp_valid_o (remap_rsp_valid),
    .slv_rsp_ready_i (remap_rsp_ready),
    .mst_req_o       (iso_req),
    .mst_req_valid_o (iso_req_valid),
    .mst_req_ready_i (iso_req_ready),
    .mst_rsp_i       (iso_rsp),
    .mst_rsp_valid_i (iso_rsp_valid),
    .mst_rsp_ready_o (iso_rsp_ready)
  );

  axi_cdc_src i_axi_cdc_src (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_i            (iso_req),
    .req_valid_i      (iso_req_valid),
    .req_ready_o      (iso_req_ready),
    .rsp_o            (iso_rsp),
    .rsp_valid_o      (iso_rsp_valid),
    .rsp_ready_i      (iso_rsp_ready),
    .async_req_data_o (async_req_data_o),
    .async_req_wptr_o (async_req_wptr_o),
    .async_req_rptr_i (async_req_rptr_i),
    .async_rsp_data_i (async_rsp_data_i),
    .async_rsp_wptr_i (async_rsp_wptr_i),
    .async_rsp_rptr_o (async_rsp_rptr_o)
  );

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset low for three rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- verif/tb_ext_slv_port.sv
`timescale 1ns/100ps
`include "bridge_config.svh"

module tb_ext_slv_port
  import axi_bridge_pkg::*;
();

  localparam int DEPTH       = 1 << `LOG_DEPTH;
  localparam int NUM_IDS     = 1 << `DST_ID_W;
  localparam int N_RANDOM    = 40;
  // Random run, back-pressure burst, isolation run
  localparam int N_PLANNED   = N_RANDOM + 5 + 7;
  localparam int WDOG_CYCLES = 200 * N_PLANNED + 1000;

  logic                 clk, rst_n;
  logic                 isolate, isolated;
  src_req_t             req;
  logic                 req_valid, req_ready;
  src_rsp_t             rsp;
  logic                 rsp_valid, rsp_ready;
  dst_req_t [DEPTH-1:0] req_data;
  dst_rsp_t [DEPTH-1:0] rsp_data;
  ptr_t                 req_wptr, req_rptr, rsp_wptr, rsp_rptr;

  // Scoreboard state
  src_req_t             acc_q[$];
  src_rsp_t             rsp_exp_q[$];
  logic [`DST_ID_W-1:0] dst_q[$];
  logic [`SRC_ID_W-1:0] map_src [NUM_IDS];
  int                   map_cnt [NUM_IDS];
  int                   n_acc, n_rsp, n_checks, n_errors;
  logic                 freeze;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ext_slv_port DUT (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .isolate_i        (isolate),
    .isolated_o       (isolated),
    .req_i            (req),
    .req_valid_i      (req_valid),
    .req_ready_o      (req_ready),
    .rsp_o            (rsp),
    .rsp_valid_o      (rsp_valid),
    .rsp_ready_i      (rsp_ready),
    .async_req_data_o (req_data),
    .async_req_wptr_o (req_wptr),
    .async_req_rptr_i (req_rptr),
    .async_rsp_data_i (rsp_data),
    .async_rsp_wptr_i (rsp_wptr),
    .async_rsp_rptr_o (rsp_rptr)
  );

  function automatic ptr_t to_gray(input ptr_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic ptr_t from_gray(input ptr_t g);
    ptr_t b;
    b = g;
    for (int i = `LOG_DEPTH - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  function automatic src_req_t rand_req();
    src_req_t r;
    r.addr  = $urandom;
    r.wdata = $urandom;
    r.write = 1'($urandom % 2);
    // Six source IDs over four entries, so entries get reused and the table fills
    r.id    = `SRC_ID_W'($urandom % 6);
    return r;
  endfunction

  task automatic report_error(input string msg);
    n_errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic check_req(input string name, input dst_req_t exp, input dst_req_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_rsp(input string name, input src_rsp_t exp, input src_rsp_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Live dst ids must map one to one onto source IDs
  task automatic check_mapping(input logic [`SRC_ID_W-1:0] src_id,
                               input logic [`DST_ID_W-1:0] dst_id);
    n_checks++;
    if (map_cnt[dst_id] > 0 && map_src[dst_id] != src_id) begin
      report_error($sformatf("dst id %0d shared by source IDs %0h and %0h",
                             dst_id, map_src[dst_id], src_id));
    end
    for (int i = 0; i < NUM_IDS; i++) begin
      if (i != int'(dst_id) && map_cnt[i] > 0 && map_src[i] == src_id) begin
        report_error($sformatf("source ID %0h live on dst ids %0d and %0d",
                               src_id, i, dst_id));
      end
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("test %s: %0d errors", name, n_errors - err_start);
  endtask

  // Leaves valid high when the limit runs out
  task automatic send(input src_req_t r, input int limit, output logic ok);
    int n;
    @(posedge clk);
    req       <= r;
    req_valid <= 1'b1;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < limit) begin
      @(negedge clk);
      if (req_ready) begin
        ok = 1'b1;
      end else begin
        n++;
      end
    end
    if (ok) begin
      @(posedge clk);
      req_valid <= 1'b0;
    end
  endtask

  task automatic finish_send();
    do @(negedge clk); while (!req_ready);
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    do @(negedge clk); while (n_acc != n_rsp || acc_q.size() != 0);
  endtask

  // SoC side monitor and remote FIFO halves, sampled on the falling edge
  initial begin : remote_side
    ptr_t                  rd_bin, wr_bin, used;
    logic                  busy, adv;
    int                    delay;
    dst_req_t              cur, exp_req;
    src_req_t              src;
    src_rsp_t              exp_rsp;
    dst_rsp_t              word;
    logic [`LOG_DEPTH-1:0] slot;
    logic [`DST_ID_W-1:0]  did;
    rd_bin    = '0;
    wr_bin    = '0;
    busy      = 1'b0;
    adv       = 1'b0;
    delay     = 0;
    cur       = '0;
    word      = '0;
    slot      = '0;
    rsp_ready = 1'b0;
    req_rptr  = '0;
    rsp_wptr  = '0;
    rsp_data  = '0;
    n_acc     = 0;
    n_rsp     = 0;
    for (int i = 0; i < NUM_IDS; i++) begin
      map_cnt[i] = 0;
      map_src[i] = '0;
    end
    forever begin
      @(negedge clk);
      adv = 1'b0;
      if (rst_n) begin
        if (isolated && n_acc != n_rsp) begin
          report_error($sformatf("isolated_o high with %0d responses outstanding",
                                 n_acc - n_rsp));
        end
        if (req_valid && req_ready) begin
          if (isolate) begin
            report_error("request accepted while isolate_i was high");
          end
          acc_q.push_back(req);
          exp_rsp.rdata = req.addr ^ req.wdata;
          exp_rsp.id    = req.id;
          rsp_exp_q.push_back(exp_rsp);
          n_acc++;
        end
        if (rsp_valid && rsp_ready) begin
          if (rsp_exp_q.size() == 0) begin
            report_error("response with no request outstanding");
          end else begin
            exp_rsp = rsp_exp_q.pop_front();
            check_rsp("rsp_restore", exp_rsp, rsp);
          end
          if (dst_q.size() != 0) begin
            did = dst_q.pop_front();
            map_cnt[did]--;
          end
          n_rsp++;
        end
        // Next word is readable once the writer is ahead
        if (!busy && to_gray(rd_bin) != req_wptr) begin
          cur   = req_data[rd_bin[`LOG_DEPTH-1:0]];
          busy  = 1'b1;
          delay = int'($urandom % 6);
          if (acc_q.size() == 0) begin
            report_error("remote side got a word that was never accepted");
          end else begin
            src     = acc_q.pop_front();
            // dst id is covered by the mapping check
            exp_req = '{addr: src.addr, wdata: src.wdata, write: src.write, id: cur.id};
            check_req("req_order", exp_req, cur);
            check_mapping(src.id, cur.id);
            map_src[cur.id] = src.id;
            map_cnt[cur.id]++;
            dst_q.push_back(cur.id);
          end
        end
        used = wr_bin - from_gray(rsp_rptr);
        if (busy && !freeze) begin
          if (delay > 0) begin
            delay--;
          end else if (used < ptr_t'(DEPTH)) begin
            word.rdata = cur.addr ^ cur.wdata;
            word.id    = cur.id;
            slot       = wr_bin[`LOG_DEPTH-1:0];
            wr_bin     = wr_bin + ptr_t'(1);
            rd_bin     = rd_bin + ptr_t'(1);
            busy       = 1'b0;
            adv        = 1'b1;
          end
        end
      end
      @(posedge clk);
      rsp_ready <= ($urandom % 4) != 0;
      if (adv) begin
        rsp_data[slot] <= word;
        rsp_wptr       <= to_gray(wr_bin);
        req_rptr       <= to_gray(rd_bin);
      end
    end
  end

  initial begin : watchdog
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", WDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    logic ok;
    int   n, err0;
    void'($urandom(61));
    req       = '0;
    req_valid = 1'b0;
    isolate   = 1'b0;
    freeze    = 1'b0;
    n_checks  = 0;
    n_errors  = 0;

    err0 = n_errors;
    @(negedge clk);
    check_bit("reset_req_ready", 1'b0, req_ready);
    check_bit("reset_rsp_valid", 1'b0, rsp_valid);
    check_bit("reset_isolated", 1'b0, isolated);
    check_bit("reset_pointers", 1'b1, req_wptr == '0 && rsp_rptr == '0);
    report_test("reset", err0);
    wait (rst_n);

    err0 = n_errors;
    for (int i = 0; i < N_RANDOM; i++) begin
      send(rand_req(), WDOG_CYCLES, ok);
      repeat (int'($urandom % 3)) @(posedge clk);
    end
    wait_drain();
    report_test("random_traffic", err0);

    // Remote reader stalls, FIFO fills
    err0 = n_errors;
    @(posedge clk);
    freeze <= 1'b1;
    n  = 0;
    ok = 1'b1;
    while (ok && n < DEPTH + 1) begin
      send(rand_req(), 40, ok);
      if (ok) begin
        n++;
      end
    end
    check_bit("bp_accept_limit", 1'b1, n > 0 && n <= DEPTH);
    @(posedge clk);
    freeze <= 1'b0;
    if (!ok) begin
      finish_send();
    end
    wait_drain();
    report_test("back_pressure", err0);

    err0 = n_errors;
    for (int i = 0; i < 6; i++) begin
      send(rand_req(), WDOG_CYCLES, ok);
    end
    // A request waits at the closed gate
    @(posedge clk);
    isolate   <= 1'b1;
    req       <= rand_req();
    req_valid <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!isolated && n < 500);
    check_bit("iso_reached", 1'b1, isolated);
    check_bit("iso_blocked", 1'b0, req_ready);
    @(posedge clk);
    isolate <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!req_ready && n < 20);
    check_bit("iso_resume", 1'b1, req_ready);
    @(posedge clk);
    req_valid <= 1'b0;
    wait_drain();
    report_test("isolation", err0);

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- ext_slv_port.f
+incdir+logic
logic/axi_bridge_pkg.sv
logic/axi_id_remap.sv
logic/axi_isolate.sv
logic/axi_cdc_src.sv
logic/ext_slv_port.sv
verif/tb_clk_gen.sv
verif/tb_ext_slv_port.sv

//--- run.sh
#!/bin/sh
# Build and run tb_ext_slv_port with Verilator, then scan the log
verilator --binary --timing --assert --top-module tb_ext_slv_port -f ext_slv_port.f \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_ext_slv_port > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
